// ==== Makefile ====
RTL := common/mips_pkg.sv common/pipe_ifs.sv hdl/decode_stage.sv \
       hdl/execute_stage.sv hdl/memory_stage.sv hdl/mips_pipe_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module mips_pipe_tb -f src.f

run: build
	@out="$$(./obj_dir/Vmips_pipe_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --top-module mips_pipe_top $(RTL)

clean:
	rm -rf obj_dir

// ==== bench/mips_pipe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_pipe_tb import mips_pkg::*; ();

  localparam int clk_period = 20;
  localparam int n_insts    = 55;   // Instructions issued over all tests

  typedef struct {
    logic [reg_addr_w-1:0] dest;
    logic [word_w-1:0]     data;
    int                    edge_n;   // Clock edge that retires it when never frozen
    int                    frz;      // Frozen edge count at issue
  } wb_item_t;

  logic                  clk;
  logic                  rst_b;
  logic                  freeze;
  logic                  inst_valid;
  logic [word_w-1:0]     inst;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_dest;
  logic [word_w-1:0]     wb_data;

  logic [word_w-1:0]     ref_regs [2**reg_addr_w];
  logic [7:0]            ref_mem [dmem_bytes];
  wb_item_t              pending [$];

  integer seed         = 2;
  int     cycle_cnt    = 0;
  int     frozen_cnt   = 0;
  int     errors       = 0;
  int     checks       = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  mips_pipe_top DUT (
    .clk        (clk),
    .rst_b      (rst_b),
    .freeze     (freeze),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_dest    (wb_dest),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("Mismatch at %0d ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Sampled at the edge before the DUT registers update
  always @(posedge clk) begin
    wb_item_t item;
    cycle_cnt = cycle_cnt + 1;
    if (freeze) begin
      frozen_cnt = frozen_cnt + 1;   // Held writeback does not retire
    end else if (wb_valid) begin
      if (pending.size() == 0) begin
        $display("Error at %0d ns: writeback to r%0d with no instruction pending",
                 $time, wb_dest);
        errors++;
      end else begin
        item = pending.pop_front();
        compare("wb_dest", 32'(item.dest), 32'(wb_dest));
        compare("wb_data", item.data, wb_data);
        compare("retire cycle", item.edge_n + (frozen_cnt - item.frz), cycle_cnt);
      end
    end
  end

  function automatic logic [31:0] rtype_inst(input logic [5:0] fn, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
    return {6'd0, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype_inst(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Reference model updated in issue order
  task automatic predict(input logic [word_w-1:0] w);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  dest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [7:0]  addr;
    logic        wr;
    wb_item_t    item;
    op   = w[31:26];
    fn   = w[5:0];
    a    = ref_regs[w[25:21]];
    b    = ref_regs[w[20:16]];
    imm  = {{16{w[15]}}, w[15:0]};
    addr = 8'(a + imm);
    dest = w[20:16];
    res  = '0;
    wr   = 1'b0;
    case (op)
      op_rtype: begin
        dest = w[15:11];
        wr   = 1'b1;
        case (fn)
          fn_add:  res = a + b;
          fn_sub:  res = a - b;
          fn_and:  res = a & b;
          fn_or:   res = a | b;
          fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      op_addi: begin
        res = a + imm;
        wr  = 1'b1;
      end
      op_lw: begin
        for (int i = 0; i < 4; i++) begin
          res[8*i +: 8] = ref_mem[{addr[7:2], 2'(i)}];   // Little endian
        end
        wr = 1'b1;
      end
      op_lb: begin
        res = {{24{ref_mem[addr][7]}}, ref_mem[addr]};
        wr  = 1'b1;
      end
      op_sw: begin
        for (int i = 0; i < 4; i++) begin
          ref_mem[{addr[7:2], 2'(i)}] = b[8*i +: 8];
        end
      end
      op_sb: ref_mem[addr] = b[7:0];
      default: ;
    endcase
    if (wr && dest != 5'd0) begin
      ref_regs[dest] = res;
      item.dest      = dest;
      item.data      = res;
      item.edge_n    = cycle_cnt + 4;
      item.frz       = frozen_cnt;
      pending.push_back(item);
    end
  endtask

  // Called just after a falling edge
  task automatic strobe(input logic [word_w-1:0] w, input int gap);
    inst_valid = 1'b1;
    inst       = w;
    if (!freeze) begin
      predict(w);   // A frozen strobe is lost
    end
    @(negedge clk);
    inst_valid = 1'b0;
    repeat (gap - 1) @(negedge clk);
  endtask

  task automatic drain();
    while (pending.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);   // Catch stray writebacks
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_alu();
    int err0;
    err0 = errors;
    for (int r = 1; r <= 6; r++) begin
      strobe(itype_inst(op_addi, 5'(r), 5'd0, 16'($random(seed))), 4);
    end
    strobe(itype_inst(op_addi, 5'd7, 5'd0, 16'hfffb), 4);   // -5
    strobe(rtype_inst(fn_add, 5'd10, 5'd1, 5'd2), 4);
    strobe(rtype_inst(fn_sub, 5'd11, 5'd3, 5'd4), 4);
    strobe(rtype_inst(fn_and, 5'd12, 5'd5, 5'd6), 4);
    strobe(rtype_inst(fn_or, 5'd13, 5'd1, 5'd6), 4);
    strobe(rtype_inst(fn_slt, 5'd14, 5'd7, 5'd2), 4);
    strobe(rtype_inst(fn_slt, 5'd15, 5'd2, 5'd7), 4);
    strobe(rtype_inst(fn_slt, 5'd16, 5'd3, 5'd4), 4);
    drain();
    report_test("test 1 alu", err0);
  endtask

  task automatic test_reg_zero();
    int err0;
    err0 = errors;
    strobe(itype_inst(op_addi, 5'd0, 5'd0, 16'd123), 4);
    strobe(rtype_inst(6'd0, 5'd9, 5'd1, 5'd2), 4);     // Unknown funct
    strobe(itype_inst(6'd15, 5'd9, 5'd1, 16'd7), 4);   // Unknown opcode
    strobe(rtype_inst(fn_add, 5'd5, 5'd0, 5'd0), 4);
    drain();
    report_test("test 2 register zero", err0);
  endtask

  task automatic test_word_mem();
    int err0;
    int bases [3];
    int offs [3];
    err0  = errors;
    bases = '{16, 100, 250};
    offs  = '{0, 8, 10};   // 250 + 10 wraps to 4
    for (int i = 0; i < 3; i++) begin
      strobe(itype_inst(op_addi, 5'd1, 5'd0, 16'(bases[i])), 4);
      strobe(itype_inst(op_addi, 5'd2, 5'd0, 16'($random(seed))), 4);
      strobe(itype_inst(op_sw, 5'd2, 5'd1, 16'(offs[i])), 4);
      strobe(itype_inst(op_lw, 5'd3, 5'd1, 16'(offs[i])), 4);
    end
    strobe(itype_inst(op_lw, 5'd4, 5'd0, 16'd4), 4);
    drain();
    report_test("test 3 word memory", err0);
  endtask

  task automatic test_byte_mem();
    int         err0;
    logic [7:0] vals [4];
    err0 = errors;
    vals = '{8'h11, 8'h22, 8'h33, 8'hf4};
    strobe(itype_inst(op_addi, 5'd1, 5'd0, 16'h0040), 4);
    for (int i = 0; i < 4; i++) begin
      strobe(itype_inst(op_addi, 5'd2, 5'd0, {8'h00, vals[i]}), 4);
      strobe(itype_inst(op_sb, 5'd2, 5'd1, 16'(i)), 4);
    end
    strobe(itype_inst(op_lw, 5'd3, 5'd1, 16'd0), 4);
    strobe(itype_inst(op_lb, 5'd4, 5'd1, 16'd3), 4);
    strobe(itype_inst(op_lb, 5'd5, 5'd1, 16'd1), 4);
    compare("model r3", 32'hf4332211, ref_regs[3]);
    compare("model r4", 32'hfffffff4, ref_regs[4]);
    drain();
    report_test("test 4 byte memory", err0);
  endtask

  task automatic test_back_to_back();
    int err0;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      strobe(itype_inst(op_addi, 5'(11 + i), 5'd0, 16'($random(seed))), 1);
    end
    drain();
    report_test("test 5 back to back", err0);
  endtask

  task automatic test_freeze();
    int err0;
    err0 = errors;
    strobe(itype_inst(op_addi, 5'd21, 5'd0, 16'd21), 1);
    strobe(itype_inst(op_addi, 5'd22, 5'd0, 16'd22), 1);
    strobe(itype_inst(op_addi, 5'd23, 5'd0, 16'd23), 1);
    freeze = 1'b1;   // First writeback is now on the outputs
    strobe(itype_inst(op_addi, 5'd24, 5'd0, 16'd24), 1);
    repeat (4) @(negedge clk);
    freeze = 1'b0;
    drain();
    report_test("test 6 freeze", err0);
  endtask

  initial begin
    rst_b      = 1'b0;
    freeze     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < 2**reg_addr_w; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    @(negedge clk);
    test_alu();
    test_reg_zero();
    test_word_mem();
    test_byte_mem();
    test_back_to_back();
    test_freeze();
    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(clk_period * (n_insts * 10 + 200));
    $display("Timeout: the tests did not finish within %0d cycles", n_insts * 10 + 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  localparam int word_w      = 32;
  localparam int reg_addr_w  = 5;
  localparam int dmem_bytes  = 256;
  localparam int dmem_addr_w = 8;   // log2(dmem_bytes), addresses wrap

  // Primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'd0,
    op_addi  = 6'd8,
    op_lb    = 6'd32,
    op_lw    = 6'd35,
    op_sb    = 6'd40,
    op_sw    = 6'd43
  } opcode_e;

  // R-type function field, inst[5:0]
  typedef enum logic [5:0] {
    fn_add = 6'd32,
    fn_sub = 6'd34,
    fn_and = 6'd36,
    fn_or  = 6'd37,
    fn_slt = 6'd42
  } funct_e;

  // Operation handed from decode to execute
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

endpackage

`default_nettype wire

// ==== common/pipe_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decode to execute pipeline register
interface decode_ex_if import mips_pkg::*; ();

  logic                  valid;
  alu_op_e               alu_op;
  logic [word_w-1:0]     operand_a;   // rs data
  logic [word_w-1:0]     operand_b;   // rt data or immediate
  logic [word_w-1:0]     rt_data;     // Store data
  logic                  mem_write;
  logic                  mem_read;
  logic                  is_byte;
  logic                  reg_write;
  logic [reg_addr_w-1:0] dest;

  modport src (
    output valid, alu_op, operand_a, operand_b, rt_data,
           mem_write, mem_read, is_byte, reg_write, dest
  );

  modport dst (
    input valid, alu_op, operand_a, operand_b, rt_data,
          mem_write, mem_read, is_byte, reg_write, dest
  );

endinterface

// Execute to memory pipeline register
interface ex_mem_if import mips_pkg::*; ();

  logic                  valid;
  logic [word_w-1:0]     alu_result;
  logic [word_w-1:0]     rt_data;
  logic                  mem_write;
  logic                  mem_read;
  logic                  is_byte;
  logic                  reg_write;
  logic [reg_addr_w-1:0] dest;

  modport src (
    output valid, alu_result, rt_data, mem_write, mem_read,
           is_byte, reg_write, dest
  );

  modport dst (
    input valid, alu_result, rt_data, mem_write, mem_read,
          is_byte, reg_write, dest
  );

endinterface

// Memory to writeback register
interface mem_wb_if import mips_pkg::*; ();

  logic                  valid;
  logic                  reg_write;
  logic [reg_addr_w-1:0] dest;
  logic [word_w-1:0]     result;   // Load data or ALU result

  modport src (output valid, reg_write, dest, result);

  modport dst (input valid, reg_write, dest, result);

endinterface

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage import mips_pkg::*; (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              freeze,
  input  logic              inst_valid,
  input  logic [word_w-1:0] inst,
  mem_wb_if.dst             wb,
  decode_ex_if.src          dx
);

  logic [word_w-1:0]     regs [1:2**reg_addr_w-1];   // Entry 0 is not stored

  opcode_e               opcode;
  funct_e                funct;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [reg_addr_w-1:0] rd;
  logic [word_w-1:0]     imm_ext;
  logic [word_w-1:0]     rs_data;
  logic [word_w-1:0]     rt_data;

  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  mem_write;
  logic                  mem_read;
  logic                  is_byte;
  logic                  reg_write;
  logic [reg_addr_w-1:0] dest;

  assign opcode  = opcode_e'(inst[31:26]);
  assign rs      = inst[25:21];
  assign rt      = inst[20:16];
  assign rd      = inst[15:11];
  assign funct   = funct_e'(inst[5:0]);
  assign imm_ext = {{(word_w-16){inst[15]}}, inst[15:0]};

  // Register file, written from writeback
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int i = 1; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.reg_write && (wb.dest != '0)) begin
      regs[wb.dest] <= wb.result;
    end
  end

  assign rs_data = (rs == '0) ? '0 : regs[rs];
  assign rt_data = (rt == '0) ? '0 : regs[rt];

  always_comb begin
    alu_op    = alu_add;   // Address calc for memory ops
    use_imm   = 1'b1;
    mem_write = 1'b0;
    mem_read  = 1'b0;
    is_byte   = 1'b0;
    reg_write = 1'b0;
    dest      = rt;
    case (opcode)
      op_rtype: begin
        use_imm   = 1'b0;
        dest      = rd;
        reg_write = 1'b1;
        case (funct)
          fn_add:  alu_op = alu_add;
          fn_sub:  alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_slt:  alu_op = alu_slt;
          default: reg_write = 1'b0;   // Unknown funct is a no-op
        endcase
      end
      op_addi: reg_write = 1'b1;
      op_lw: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      op_lb: begin
        mem_read  = 1'b1;
        is_byte   = 1'b1;
        reg_write = 1'b1;
      end
      op_sw: mem_write = 1'b1;
      op_sb: begin
        mem_write = 1'b1;
        is_byte   = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      dx.valid     <= 1'b0;
      dx.mem_write <= 1'b0;
      dx.mem_read  <= 1'b0;
      dx.reg_write <= 1'b0;
    end else if (!freeze) begin
      dx.valid     <= inst_valid;   // Strobe during freeze is dropped
      dx.mem_write <= mem_write;
      dx.mem_read  <= mem_read;
      dx.reg_write <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      dx.alu_op    <= alu_op;
      dx.operand_a <= rs_data;
      dx.operand_b <= use_imm ? imm_ext : rt_data;
      dx.rt_data   <= rt_data;
      dx.is_byte   <= is_byte;
      dx.dest      <= dest;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage import mips_pkg::*; (
  input  logic     clk,
  input  logic     rst_b,
  input  logic     freeze,
  decode_ex_if.dst dx,
  ex_mem_if.src    xm
);

  logic [word_w-1:0] alu_result;
  logic              less;

  assign less = $signed(dx.operand_a) < $signed(dx.operand_b);

  always_comb begin
    case (dx.alu_op)
      alu_add: alu_result = dx.operand_a + dx.operand_b;
      alu_sub: alu_result = dx.operand_a - dx.operand_b;
      alu_and: alu_result = dx.operand_a & dx.operand_b;
      alu_or:  alu_result = dx.operand_a | dx.operand_b;
      alu_slt: alu_result = {{(word_w-1){1'b0}}, less};
      default: alu_result = dx.operand_a + dx.operand_b;
    endcase
  end

  // Execute to memory register
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      xm.valid      <= 1'b0;
      xm.alu_result <= '0;
      xm.rt_data    <= '0;
      xm.mem_write  <= 1'b0;
      xm.mem_read   <= 1'b0;
      xm.is_byte    <= 1'b0;
      xm.reg_write  <= 1'b0;
      xm.dest       <= '0;
    end else if (!freeze) begin
      xm.valid      <= dx.valid;
      xm.alu_result <= alu_result;
      xm.rt_data    <= dx.rt_data;
      xm.mem_write  <= dx.mem_write;
      xm.mem_read   <= dx.mem_read;
      xm.is_byte    <= dx.is_byte;
      xm.reg_write  <= dx.reg_write;
      xm.dest       <= dx.dest;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_stage import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst_b,
  input  logic  freeze,
  ex_mem_if.dst xm,
  mem_wb_if.src mw
);

  logic [7:0]             mem [dmem_bytes];   // Little-endian byte array

  logic [dmem_addr_w-1:0] addr;
  logic [dmem_addr_w-3:0] word_sel;
  logic                   store_en;
  logic [word_w-1:0]      load_word;
  logic [7:0]             load_byte;
  logic [word_w-1:0]      load_data;

  assign addr     = xm.alu_result[dmem_addr_w-1:0];
  assign word_sel = addr[dmem_addr_w-1:2];   // Word access ignores low bits
  assign store_en = xm.valid && xm.mem_write && !freeze;

  always_ff @(posedge clk) begin
    if (store_en) begin
      if (xm.is_byte) begin
        mem[addr] <= xm.rt_data[7:0];
      end else begin
        for (int i = 0; i < 4; i++) begin
          mem[{word_sel, 2'(i)}] <= xm.rt_data[8*i +: 8];
        end
      end
    end
  end

  // Combinational read sees stores from earlier cycles
  assign load_word = {mem[{word_sel, 2'd3}], mem[{word_sel, 2'd2}],
                      mem[{word_sel, 2'd1}], mem[{word_sel, 2'd0}]};
  assign load_byte = mem[addr];

  always_comb begin
    if (xm.is_byte) begin
      load_data = {{(word_w-8){load_byte[7]}}, load_byte};   // LB sign extends
    end else begin
      load_data = load_word;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mw.valid     <= 1'b0;
      mw.reg_write <= 1'b0;
    end else if (!freeze) begin
      mw.valid     <= xm.valid;
      mw.reg_write <= xm.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      mw.dest   <= xm.dest;
      mw.result <= xm.mem_read ? load_data : xm.alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mips_pipe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_pipe_top import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  freeze,
  input  logic                  inst_valid,
  input  logic [word_w-1:0]     inst,
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_dest,
  output logic [word_w-1:0]     wb_data
);

  decode_ex_if dx_bus ();
  ex_mem_if    xm_bus ();
  mem_wb_if    mw_bus ();

  decode_stage u_decode (
    .clk        (clk),
    .rst_b      (rst_b),
    .freeze     (freeze),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (mw_bus.dst),   // Writeback loops into the register file
    .dx         (dx_bus.src)
  );

  execute_stage u_execute (
    .clk    (clk),
    .rst_b  (rst_b),
    .freeze (freeze),
    .dx     (dx_bus.dst),
    .xm     (xm_bus.src)
  );

  memory_stage u_memory (
    .clk    (clk),
    .rst_b  (rst_b),
    .freeze (freeze),
    .xm     (xm_bus.dst),
    .mw     (mw_bus.src)
  );

  assign wb_valid = mw_bus.valid && mw_bus.reg_write && (mw_bus.dest != '0);
  assign wb_dest  = mw_bus.dest;
  assign wb_data  = mw_bus.result;

endmodule

`default_nettype wire

// ==== src.f ====
common/mips_pkg.sv
common/pipe_ifs.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipe_top.sv
bench/mips_pipe_tb.sv
